//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int mem_depth  = 256;
    localparam int mem_addr_w = 8;
    localparam int apb_addr_w = 12;

    typedef enum logic [1:0] {
        cmd_nop  = 2'd0,
        cmd_add  = 2'd1,
        cmd_equ  = 2'd2,
        cmd_halt = 2'd3
    } cmd_t;

    localparam logic [6:0] opc_addi   = 7'b00100_11;
    localparam logic [6:0] opc_lui    = 7'b01101_11;
    localparam logic [6:0] opc_auipc  = 7'b00101_11;
    localparam logic [6:0] opc_system = 7'b11100_11;

    // sequencer state encoding.
    localparam logic [1:0] seq_idle   = 2'd0;
    localparam logic [1:0] seq_fetch  = 2'd1;
    localparam logic [1:0] seq_exec   = 2'd2;
    localparam logic [1:0] seq_halted = 2'd3;

    typedef union packed {
        struct packed {
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u_fmt;
    } inst_u;

    // apb byte address map.
    localparam logic [apb_addr_w-1:0] apb_mem_base  = 12'h000;
    localparam logic [apb_addr_w-1:0] apb_ctrl_addr = 12'h400;
    localparam logic [apb_addr_w-1:0] apb_stat_addr = 12'h404;
    localparam logic [apb_addr_w-1:0] apb_pc_addr   = 12'h408;
    localparam logic [apb_addr_w-1:0] apb_reg_base  = 12'h800;

endpackage

//--- verilog/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import rv_core_pkg::*; ();

    logic                  req;
    logic                  we;
    logic [mem_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic [xlen-1:0]       rdata;
    logic                  ack;

    // held by the requester until ack.
    modport requester (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ack
    );

    modport memory (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

//--- verilog/inst_decode.sv
`timescale 1ns/1ps

module inst_decode import rv_core_pkg::*; (
    input  inst_u                 inst,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       rdata1,
    output logic [reg_addr_w-1:0] raddr1,
    output logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       src1,
    output logic [xlen-1:0]       src2,
    output logic [reg_addr_w-1:0] des,
    output cmd_t                  command
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            rs1_en;
    logic            rd_en;

    // sign-extended i-type and upper u-type immediates.
    assign imm_i = {{(xlen-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_u = {inst.u_fmt.imm20, 12'b0};

    assign raddr1 = rs1_en ? inst.i_fmt.rs1 : '0;
    assign des    = rd_en ? inst.i_fmt.rd : '0;

    // no second source yet.
    assign raddr2 = '0;

    always_comb begin
        command = cmd_nop;
        src1    = '0;
        src2    = '0;
        rs1_en  = 1'b0;
        rd_en   = 1'b0;
        case (inst.i_fmt.opcode)
            opc_addi: begin
                if (inst.i_fmt.funct3 == 3'b000) begin
                    command = cmd_add;
                    src1    = imm_i;
                    src2    = rdata1;
                    rs1_en  = 1'b1;
                    rd_en   = 1'b1;
                end
            end
            opc_lui: begin
                command = cmd_equ;
                src1    = imm_u;
                src2    = '0;
                rd_en   = 1'b1;
            end
            opc_auipc: begin
                command = cmd_add;
                src1    = pc;
                src2    = imm_u;
                rd_en   = 1'b1;
            end
            opc_system: begin
                // ebreak.
                command = cmd_halt;
            end
            default: begin
                command = cmd_nop;
            end
        endcase
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [reg_addr_w-1:0] raddr1,
    output logic [xlen-1:0]       rdata1,
    input  logic [reg_addr_w-1:0] dbg_raddr,
    output logic [xlen-1:0]       dbg_rdata,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [1<<reg_addr_w];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero.
    assign rdata1    = (raddr1 == '0) ? '0 : regs[raddr1];
    assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

//--- verilog/core_seq.sv
`timescale 1ns/1ps

module core_seq import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    mem_bus_if.requester          mem,
    output inst_u                 inst,
    input  logic [xlen-1:0]       src1,
    input  logic [xlen-1:0]       src2,
    input  cmd_t                  command,
    input  logic [reg_addr_w-1:0] des,
    output logic [xlen-1:0]       pc,
    output logic                  we,
    output logic [xlen-1:0]       wdata,
    output logic                  halted,
    output logic                  busy
);

    logic [1:0]            state;
    logic                  run_q;
    logic                  run_rise;
    logic                  req_q;
    logic [mem_addr_w+1:0] pc_next;

    assign run_rise = run && !run_q;

    // pc stays inside the 1 KB window.
    assign pc_next = pc[mem_addr_w+1:0] + (mem_addr_w+2)'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= seq_idle;
            run_q <= 1'b0;
            req_q <= 1'b0;
            pc    <= '0;
        end else begin
            run_q <= run;
            if (!run) begin
                state <= seq_idle;
                req_q <= 1'b0;
            end else if (run_rise) begin
                state <= seq_fetch;
                req_q <= 1'b1;
                pc    <= '0;
            end else begin
                case (state)
                    seq_fetch: begin
                        if (mem.ack) begin
                            req_q <= 1'b0;
                            state <= seq_exec;
                        end
                    end
                    seq_exec: begin
                        if (command == cmd_halt) begin
                            state <= seq_halted;
                        end else begin
                            pc    <= xlen'(pc_next);
                            req_q <= 1'b1;
                            state <= seq_fetch;
                        end
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == seq_fetch) && mem.ack) begin
            inst <= mem.rdata;
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = pc[mem_addr_w+1:2];
    assign mem.wdata = '0;

    always_comb begin
        case (command)
            cmd_add: wdata = src1 + src2;
            cmd_equ: wdata = src1;
            default: wdata = '0;
        endcase
    end

    // decoder clears des when nothing is written.
    assign we     = (state == seq_exec) && (des != '0);
    assign halted = (state == seq_halted);
    assign busy   = (state == seq_fetch) || (state == seq_exec);

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import rv_core_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    mem_bus_if.arbiter   apb_side,
    mem_bus_if.arbiter   core_side,
    mem_bus_if.requester mem_side
);

    logic locked;
    logic owner_apb;
    logic grant_apb;

    // apb wins when both ask.
    assign grant_apb = apb_side.req;

    assign mem_side.req   = !locked && (apb_side.req || core_side.req);
    assign mem_side.we    = grant_apb ? apb_side.we : core_side.we;
    assign mem_side.addr  = grant_apb ? apb_side.addr : core_side.addr;
    assign mem_side.wdata = grant_apb ? apb_side.wdata : core_side.wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked    <= 1'b0;
            owner_apb <= 1'b0;
        end else if (!locked) begin
            if (mem_side.req) begin
                locked    <= 1'b1;
                owner_apb <= grant_apb;
            end
        end else if (mem_side.ack) begin
            locked <= 1'b0;
        end
    end

    // ack goes back to whoever holds the grant.
    assign apb_side.ack  = locked && owner_apb && mem_side.ack;
    assign core_side.ack = locked && !owner_apb && mem_side.ack;

    assign apb_side.rdata  = mem_side.rdata;
    assign core_side.rdata = mem_side.rdata;

endmodule

//--- verilog/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import rv_core_pkg::*; (
    input logic       clk,
    mem_bus_if.memory bus
);

    logic [xlen-1:0] mem_q [mem_depth];

    // ack and data one cycle after the request.
    always_ff @(posedge clk) begin
        bus.ack <= bus.req;
        if (bus.req) begin
            if (bus.we) begin
                mem_q[bus.addr] <= bus.wdata;
            end
            bus.rdata <= mem_q[bus.addr];
        end
    end

endmodule

//--- verilog/apb_ctrl.sv
`timescale 1ns/1ps

module apb_ctrl import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [xlen-1:0]       pwdata,
    output logic [xlen-1:0]       prdata,
    output logic                  pready,
    output logic                  pslverr,
    mem_bus_if.requester          mem,
    output logic                  run,
    input  logic                  halted,
    input  logic                  busy,
    input  logic [xlen-1:0]       pc,
    output logic [reg_addr_w-1:0] dbg_raddr,
    input  logic [xlen-1:0]       dbg_rdata
);

    logic                  hit_mem;
    logic                  hit_ctrl;
    logic                  hit_stat;
    logic                  hit_pc;
    logic                  hit_reg;
    logic                  hit_none;
    logic                  setup;
    logic                  access;
    logic                  ro_write;
    logic                  req_q;
    logic                  we_q;
    logic [mem_addr_w-1:0] addr_q;
    logic [xlen-1:0]       wdata_q;

    assign hit_mem = paddr[apb_addr_w-1:mem_addr_w+2] ==
                     apb_mem_base[apb_addr_w-1:mem_addr_w+2];
    assign hit_ctrl = (paddr == apb_ctrl_addr);
    assign hit_stat = (paddr == apb_stat_addr);
    assign hit_pc   = (paddr == apb_pc_addr);
    assign hit_reg = paddr[apb_addr_w-1:reg_addr_w+2] ==
                     apb_reg_base[apb_addr_w-1:reg_addr_w+2];
    assign hit_none = !(hit_mem || hit_ctrl || hit_stat || hit_pc || hit_reg);

    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign ro_write = pwrite && (hit_stat || hit_pc || hit_reg);

    // memory window waits for the ack.
    assign pready  = access && (!hit_mem || mem.ack);
    assign pslverr = access && !hit_mem && (hit_none || ro_write);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= 1'b0;
            we_q  <= 1'b0;
            run   <= 1'b0;
        end else begin
            if (setup && hit_mem) begin
                req_q <= 1'b1;
                we_q  <= pwrite;
            end else if (mem.ack) begin
                req_q <= 1'b0;
            end
            if (access && pwrite && hit_ctrl) begin
                run <= pwdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup && hit_mem) begin
            addr_q  <= paddr[mem_addr_w+1:2];
            wdata_q <= pwdata;
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = we_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    assign dbg_raddr = paddr[reg_addr_w+1:2];

    always_comb begin
        prdata = '0;
        if (hit_mem) begin
            prdata = mem.rdata;
        end else if (hit_ctrl) begin
            prdata = {{(xlen-1){1'b0}}, run};
        end else if (hit_stat) begin
            prdata = {{(xlen-2){1'b0}}, busy, halted};
        end else if (hit_pc) begin
            prdata = pc;
        end else if (hit_reg) begin
            prdata = dbg_rdata;
        end
    end

endmodule

//--- verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [xlen-1:0]       pwdata,
    output logic [xlen-1:0]       prdata,
    output logic                  pready,
    output logic                  pslverr
);

    mem_bus_if apb_bus ();
    mem_bus_if core_bus ();
    mem_bus_if ram_bus ();

    logic                  run;
    logic                  halted;
    logic                  busy;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] dbg_raddr;
    logic [xlen-1:0]       dbg_rdata;
    inst_u                 inst;
    logic [reg_addr_w-1:0] raddr1;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    logic [reg_addr_w-1:0] des;
    cmd_t                  command;
    logic                  rf_we;
    logic [xlen-1:0]       rf_wdata;

    apb_ctrl u_apb_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .mem       (apb_bus.requester),
        .run       (run),
        .halted    (halted),
        .busy      (busy),
        .pc        (pc),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .apb_side  (apb_bus.arbiter),
        .core_side (core_bus.arbiter),
        .mem_side  (ram_bus.requester)
    );

    inst_mem u_inst_mem (
        .clk (clk),
        .bus (ram_bus.memory)
    );

    core_seq u_core_seq (
        .clk     (clk),
        .arst_n  (arst_n),
        .run     (run),
        .mem     (core_bus.requester),
        .inst    (inst),
        .src1    (src1),
        .src2    (src2),
        .command (command),
        .des     (des),
        .pc      (pc),
        .we      (rf_we),
        .wdata   (rf_wdata),
        .halted  (halted),
        .busy    (busy)
    );

    inst_decode u_inst_decode (
        .inst    (inst),
        .pc      (pc),
        .rdata1  (rdata1),
        .raddr1  (raddr1),
        .raddr2  (),
        .src1    (src1),
        .src2    (src2),
        .des     (des),
        .command (command)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .raddr1    (raddr1),
        .rdata1    (rdata1),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata),
        .we        (rf_we),
        .waddr     (des),
        .wdata     (rf_wdata)
    );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          prog_len    = 40;
    localparam int          total_insts = 3 * prog_len + 4;
    localparam int          cycle_limit = 200 * total_insts + 2000;
    localparam logic [11:0] ctrl_addr   = 12'h400;
    localparam logic [11:0] stat_addr   = 12'h404;
    localparam logic [11:0] pc_addr     = 12'h408;
    localparam logic [11:0] reg_base    = 12'h800;
    localparam logic [6:0]  opc_addi    = 7'h13;
    localparam logic [6:0]  opc_lui     = 7'h37;
    localparam logic [6:0]  opc_auipc   = 7'h17;
    localparam logic [6:0]  opc_system  = 7'h73;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr_state;
    logic [31:0] prog [256];
    logic [31:0] ref_regs [32];
    int          check_count;
    int          mismatch_count;
    int          fail_count;
    int          cycle_count;

    tb_clock_gen u_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_core_top u_rv_core_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // galois lfsr stepped once per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]};
            if (bit_out) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm20, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm20, rd, opc};
    endfunction

    // first word writes x0 and the last word is ebreak.
    function automatic void gen_program(input int n);
        logic [2:0]  choice;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        logic [19:0] imm20;
        logic [2:0]  f3;
        imm     = 12'(take_bits(12));
        rs1     = 5'(take_bits(5));
        prog[0] = enc_i(imm, rs1, 3'd0, 5'd0, opc_addi);
        for (int i = 1; i < n - 1; i++) begin
            choice = 3'(take_bits(3));
            rd     = 5'(take_bits(5));
            rs1    = 5'(take_bits(5));
            imm    = 12'(take_bits(12));
            imm20  = 20'(take_bits(20));
            f3     = 3'(take_bits(3));
            case (choice)
                3'd3: prog[i] = enc_u(imm20, rd, opc_lui);
                3'd4: prog[i] = enc_u(imm20, rd, opc_auipc);
                // r-type opcode retires as a no-op.
                3'd5: prog[i] = enc_i(imm, rs1, 3'd0, rd, 7'h33);
                3'd6: begin
                    if (f3 == 3'd0) begin
                        f3 = 3'd1;
                    end
                    prog[i] = enc_i(imm, rs1, f3, rd, opc_addi);
                end
                default: prog[i] = enc_i(imm, rs1, 3'd0, rd, opc_addi);
            endcase
        end
        prog[n-1] = ebreak_word;
    endfunction

    // executes prog on ref_regs and returns the byte address of the ebreak.
    function automatic logic [31:0] run_reference();
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] result;
        logic        wr;
        pc = '0;
        for (int step = 0; step < 1024; step++) begin
            word = prog[pc[9:2]];
            if (word[6:0] == opc_system) begin
                return pc;
            end
            result = '0;
            wr     = 1'b1;
            case (word[6:0])
                opc_addi: begin
                    result = ref_regs[word[19:15]] + {{20{word[31]}}, word[31:20]};
                    wr     = (word[14:12] == 3'd0);
                end
                opc_lui:   result = {word[31:12], 12'h000};
                opc_auipc: result = pc + {word[31:12], 12'h000};
                default:   wr = 1'b0;
            endcase
            if (wr && (word[11:7] != 5'd0)) begin
                ref_regs[word[11:7]] = result;
            end
            pc = {22'd0, pc[9:0] + 10'd4};
        end
        return pc;
    endfunction

    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_transfer(1'b1, addr, data, unused, err);
        if (err !== 1'b0) begin
            fail_count++;
            $display("write to 0x%03h was answered with pslverr", addr);
        end
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_transfer(1'b0, addr, 32'h0, data, err);
        if (err !== 1'b0) begin
            fail_count++;
            $display("read from 0x%03h was answered with pslverr", addr);
        end
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic expect_error(input logic wr, input logic [11:0] addr);
        logic [31:0] unused;
        logic        err;
        apb_transfer(wr, addr, 32'hdead_beef, unused, err);
        check_count++;
        if (err !== 1'b1) begin
            fail_count++;
            $display("no pslverr on %s at address 0x%03h", wr ? "write" : "read", addr);
        end
    endtask

    task automatic load_program(input int n);
        for (int i = 0; i < n; i++) begin
            apb_write(12'(4 * i), prog[i]);
        end
    endtask

    // a rising edge of run restarts from pc 0.
    task automatic start_core();
        apb_write(ctrl_addr, 32'h0);
        apb_write(ctrl_addr, 32'h1);
    endtask

    task automatic wait_halted();
        logic [31:0] stat;
        stat = '0;
        while (stat[0] !== 1'b1) begin
            apb_read(stat_addr, stat);
        end
    endtask

    task automatic check_core(input logic [31:0] halt_pc);
        logic [31:0] value;
        apb_read(stat_addr, value);
        expect_word("status", value, 32'h1);
        apb_read(pc_addr, value);
        expect_word("pc", value, halt_pc);
        for (int r = 0; r < 32; r++) begin
            apb_read(reg_base + 12'(4 * r), value);
            expect_word($sformatf("x%0d", r), value, ref_regs[r]);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("checks: %0d, mismatches: %0d, other errors: %0d",
                     check_count, mismatch_count, fail_count + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [31:0] halt_pc;
        logic [31:0] value;
        logic [7:0]  win_addr [8];
        logic [31:0] win_data [8];
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        lfsr_state     = 32'd66;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        cycle_count    = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        @(posedge arst_n);
        repeat (2) @(posedge clk);

        if ((pready !== 1'b0) || (pslverr !== 1'b0)) begin
            fail_count++;
            $display("pready or pslverr is not low after reset");
        end
        apb_read(ctrl_addr, value);
        expect_word("ctrl", value, 32'h0);
        apb_read(stat_addr, value);
        expect_word("status", value, 32'h0);
        apb_read(pc_addr, value);
        expect_word("pc", value, 32'h0);

        // memory window round trip.
        for (int i = 0; i < 8; i++) begin
            win_addr[i] = 8'(i * 32 + int'(take_bits(5)));
            win_data[i] = take_bits(32);
            apb_write({2'b00, win_addr[i], 2'b00}, win_data[i]);
        end
        for (int i = 0; i < 8; i++) begin
            apb_read({2'b00, win_addr[i], 2'b00}, value);
            expect_word("mem", value, win_data[i]);
        end

        expect_error(1'b0, 12'h40C);
        expect_error(1'b0, 12'hC00);
        expect_error(1'b1, stat_addr);
        expect_error(1'b1, pc_addr);
        expect_error(1'b1, 12'h804);

        // memory reads race the core's fetches.
        gen_program(prog_len);
        load_program(prog_len);
        halt_pc = run_reference();
        start_core();
        // busy and not yet halted early in the run.
        apb_read(stat_addr, value);
        expect_word("status", value, 32'h2);
        for (int i = 0; i < 8; i++) begin
            apb_read(12'(4 * i), value);
            expect_word("mem", value, prog[i]);
        end
        wait_halted();
        check_core(halt_pc);

        // rerun on top of the current register state.
        halt_pc = run_reference();
        start_core();
        wait_halted();
        check_core(halt_pc);

        gen_program(prog_len);
        load_program(prog_len);
        halt_pc = run_reference();
        start_core();
        wait_halted();
        check_core(halt_pc);

        // load, slti and jal all retire as no-ops.
        prog[0] = enc_i(12'h123, 5'd1, 3'd0, 5'd5, 7'h03);
        prog[1] = enc_i(12'h7ff, 5'd2, 3'd2, 5'd6, opc_addi);
        prog[2] = enc_u(20'h12345, 5'd7, 7'h6f);
        prog[3] = ebreak_word;
        load_program(4);
        halt_pc = run_reference();
        start_core();
        wait_halted();
        check_core(halt_pc);

        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, fail_count);
        if ((mismatch_count == 0) && (fail_count == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/rv_core_pkg.sv
verilog/mem_bus_if.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/core_seq.sv
verilog/mem_arbiter.sv
verilog/inst_mem.sv
verilog/apb_ctrl.sv
verilog/rv_core_top.sv
verif/tb_clock_gen.sv
verif/tb_rv_core.sv
